// File: dv/time_dmr_tb.sv
`timescale 1ns/1ns
`default_nettype none

module time_dmr_tb
    import time_dmr_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic                clk;
    logic                arst_n;
    logic                enable;
    logic                in_valid;
    logic                in_ready;
    mac_req_t            in_req;
    logic                out_valid;
    logic                out_ready;
    mac_rsp_t            out_rsp;

    mac_rsp_t            exp_q [$];
    int                  errors;
    int                  mark;
    int                  n_rsp;
    logic                back_pressure;
    logic [RESULT_W-1:0] flip_val;

    time_dmr_top #(
        .IdSize      (ID_SIZE),
        .ResultWidth (RESULT_W)
    ) UUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .enable_i    (enable),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .in_req_i    (in_req),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .out_rsp_o   (out_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        out_ready = back_pressure ? ($urandom_range(0, 1) == 1) : 1'b1;
    end

    // Multiply-add kept modulo 2^16
    function automatic logic [RESULT_W-1:0] mac_model(input mac_req_t r);
        logic [31:0] full;
        full = r.op_a * r.op_b + r.op_c;
        return full[RESULT_W-1:0];
    endfunction

    // Each accepted response must be the oldest expected one
    always @(posedge clk) begin : monitor
        mac_rsp_t want;
        if (arst_n && out_valid && out_ready) begin
            n_rsp++;
            if (exp_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                errors++;
            end else begin
                want = exp_q.pop_front();
                assert (out_rsp == want) else begin
                    $display("FAIL out_rsp_o: got %h expected %h", out_rsp, want);
                    errors++;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
    else begin
        $display("FAIL out_rsp_o: not held under back-pressure, now %h",
                 $sampled(out_rsp));
        errors++;
    end

    // After acceptance the second copy keeps the input closed
    assert property (@(posedge clk) disable iff (!arst_n)
        enable && in_valid && in_ready |=> !in_ready)
    else begin
        $display("FAIL in_ready_o: got %h expected 0 after acceptance", $sampled(in_ready));
        errors++;
    end

    // Called on a falling edge and returns on the falling edge after acceptance
    task automatic send_req(input mac_req_t req, input logic fault);
        int       t;
        mac_rsp_t want;
        want.result = mac_model(req);
        want.fault  = fault;
        exp_q.push_back(want);
        in_valid = 1'b1;
        in_req   = req;
        for (t = 0; t < TIMEOUT; t++) begin
            if (in_ready) break;
            @(negedge clk);
        end
        if (t == TIMEOUT) begin
            $display("A request was never accepted");
            errors++;
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_req   = mac_req_t'($urandom);
    endtask

    task automatic drain();
        int t;
        for (t = 0; t < TIMEOUT && exp_q.size() != 0; t++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
        // Idle cycles let a duplicate response show up
        repeat (4) @(negedge clk);
    endtask

    task automatic run_random(input int n);
        repeat (n) send_req(mac_req_t'($urandom), 1'b0);
        drain();
    endtask

    // Corrupts one bit of the next copy leaving the pipeline
    task automatic flip_result();
        int t;
        for (t = 0; t < TIMEOUT; t++) begin
            if (UUT.pipe_valid && UUT.pipe_ready) break;
            @(negedge clk);
        end
        if (t == TIMEOUT) begin
            $display("The pipeline never delivered a copy to corrupt");
            errors++;
        end else begin
            flip_val = UUT.pipe_result ^ 16'h0010;
            force UUT.pipe_result = flip_val;
            @(negedge clk);
            release UUT.pipe_result;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d errors", name, errors - mark);
        mark = errors;
    endtask

    initial begin
        int t;
        void'($urandom(32'hcf7807db));
        errors        = 0;
        mark          = 0;
        n_rsp         = 0;
        back_pressure = 1'b0;
        arst_n        = 1'b0;
        enable        = 1'b1;
        in_valid      = 1'b0;
        in_req        = '0;
        out_ready     = 1'b1;
        flip_val      = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        @(negedge clk);
        assert (in_ready === 1'b1) else begin
            $display("FAIL in_ready_o: got %h expected 1", in_ready);
            errors++;
        end
        assert (out_valid === 1'b0) else begin
            $display("FAIL out_valid_o: got %h expected 0", out_valid);
            errors++;
        end
        report_test("reset state");

        run_random(40);
        report_test("redundancy on");

        enable = 1'b0;
        run_random(40);
        report_test("redundancy off");

        back_pressure = 1'b1;
        run_random(20);
        enable = 1'b1;
        run_random(20);
        back_pressure = 1'b0;
        report_test("back-pressure");

        send_req(mac_req_t'($urandom), 1'b1);
        flip_result();
        repeat (3) send_req(mac_req_t'($urandom), 1'b0);
        drain();
        report_test("fault detection");

        send_req(mac_req_t'($urandom), 1'b0);
        assert (!in_ready) else begin
            $display("FAIL in_ready_o: got %h expected 0 during second copy", in_ready);
            errors++;
        end
        // Input data moves while the stored request is replayed
        for (t = 0; t < TIMEOUT && !in_ready; t++) begin
            in_req = mac_req_t'($urandom);
            @(negedge clk);
        end
        if (t == TIMEOUT) begin
            $display("The input never reopened after the second copy");
            errors++;
        end
        drain();
        report_test("input handshake");

        $display("%0d responses checked, %0d errors", n_rsp, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/time_dmr_pkg.sv
hw/time_dmr_start.sv
hw/mac_pipeline.sv
hw/time_dmr_end.sv
hw/time_dmr_top.sv
dv/time_dmr_tb.sv

// File: hw/mac_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module mac_pipeline
    import time_dmr_pkg::*;
#(
    parameter int IdSize      = ID_SIZE,
    parameter int ResultWidth = RESULT_W
) (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    input  wire                    valid_i,
    output logic                   ready_o,
    input  wire mac_req_t          req_i,
    input  wire [IdSize-1:0]       id_i,
    output logic                   valid_o,
    input  wire                    ready_i,
    output logic [ResultWidth-1:0] result_o,
    output logic [IdSize-1:0]      id_o
);

    logic                   v1_q, v2_q, v3_q;
    logic                   en1, en2, en3;
    mac_req_t               s1_q;
    mac_stage_t             s2_q;
    logic [ResultWidth-1:0] s3_q;
    logic [IdSize-1:0]      id1_q, id2_q, id3_q;

    // A stage loads when empty or when the next one moves
    assign en3 = !v3_q || ready_i;
    assign en2 = !v2_q || en3;
    assign en1 = !v1_q || en2;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else begin
            if (en1) v1_q <= valid_i;
            if (en2) v2_q <= v1_q;
            if (en3) v3_q <= v2_q;
        end
    end

    // Data and id move together
    always_ff @(posedge clk_i) begin
        if (en1) begin
            s1_q  <= req_i;
            id1_q <= id_i;
        end
        if (en2) begin
            s2_q.product <= s1_q.op_a * s1_q.op_b;
            s2_q.addend  <= s1_q.op_c;
            id2_q        <= id1_q;
        end
        if (en3) begin
            s3_q  <= s2_q.product + s2_q.addend;
            id3_q <= id2_q;
        end
    end

    assign ready_o  = en1;
    assign valid_o  = v3_q;
    assign result_o = s3_q;
    assign id_o     = id3_q;

endmodule

`default_nettype wire

// File: hw/time_dmr_end.sv
`timescale 1ns/1ns
`default_nettype none

module time_dmr_end
    import time_dmr_pkg::*;
#(
    parameter int IdSize      = ID_SIZE,
    parameter int ResultWidth = RESULT_W
) (
    input  wire                   clk_i,
    input  wire                   arst_n_i,
    input  wire                   enable_i,

    // From the pipeline
    input  wire                   valid_i,
    output logic                  ready_o,
    input  wire [ResultWidth-1:0] result_i,
    input  wire [IdSize-1:0]      id_i,

    // Response towards the outside
    output logic                  valid_o,
    input  wire                   ready_i,
    output mac_rsp_t              rsp_o
);

    logic                   first_q;
    logic [ResultWidth-1:0] first_result_q;
    logic [IdSize-1:0]      first_id_q;
    logic                   out_valid_q;
    mac_rsp_t               rsp_d;
    mac_rsp_t               rsp_q;
    logic                   out_free;
    logic                   in_fire;
    logic                   capture_first;
    logic                   emit;
    logic                   pair_fault;

    // Output register is free when empty or draining this cycle
    assign out_free = !out_valid_q || ready_i;

    // The first copy only goes into the store, which is empty then
    assign ready_o       = (enable_i && !first_q) ? 1'b1 : out_free;
    assign in_fire       = valid_i && ready_o;
    assign capture_first = in_fire && enable_i && !first_q;
    assign emit          = in_fire && !capture_first;

    always_comb begin
        // Copies disagree, ids do not pair, or the stored id was upset
        pair_fault = (first_result_q != result_i) ||
                     (first_id_q != id_i) ||
                     (^first_id_q);

        rsp_d.result = result_i;
        rsp_d.fault  = ^id_i;
        if (enable_i) begin
            rsp_d.fault = rsp_d.fault || pair_fault;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            first_q     <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (capture_first) begin
                first_q <= 1'b1;
            end else if (emit) begin
                first_q <= 1'b0;
            end

            // Response is held until taken
            if (emit) begin
                out_valid_q <= 1'b1;
            end else if (ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_first) begin
            first_result_q <= result_i;
            first_id_q     <= id_i;
        end
        if (emit) begin
            rsp_q <= rsp_d;
        end
    end

    assign valid_o = out_valid_q;
    assign rsp_o   = rsp_q;

endmodule

`default_nettype wire

// File: hw/time_dmr_pkg.sv
`default_nettype none

package time_dmr_pkg;

    // Two counter bits plus one parity bit
    localparam int ID_SIZE = 3;

    // Arithmetic is kept modulo 2^16
    localparam int RESULT_W = 16;

    typedef struct packed {
        logic [7:0]          op_a;
        logic [7:0]          op_b;
        logic [RESULT_W-1:0] op_c;
    } mac_req_t;

    typedef struct packed {
        logic [RESULT_W-1:0] result;
        logic                fault;
    } mac_rsp_t;

    // Item between the multiply and add stages of the pipeline
    typedef struct packed {
        logic [RESULT_W-1:0] product;
        logic [RESULT_W-1:0] addend;
    } mac_stage_t;

endpackage

`default_nettype wire

// File: hw/time_dmr_start.sv
`timescale 1ns/1ns
`default_nettype none

`include "tmr_voters.svh"

module time_dmr_start
    import time_dmr_pkg::*;
#(
    parameter int IdSize = ID_SIZE
) (
    input  wire               clk_i,
    input  wire               arst_n_i,
    input  wire               enable_i,

    // Upstream side
    input  wire               valid_i,
    output logic              ready_o,
    input  wire mac_req_t     data_i,

    // Downstream side
    output logic              valid_o,
    input  wire               ready_i,
    output mac_req_t          data_o,
    output logic [IdSize-1:0] id_o
);

    typedef enum logic [1:0] {
        STORE_AND_SEND,
        SEND,
        REPLICATE
    } state_t;

    state_t            state_v [3];
    state_t            state_d [3];
    state_t            state_q [3];
    mac_req_t          data_d  [3];
    mac_req_t          data_q  [3];
    logic [IdSize-1:0] id_v    [3];
    logic [IdSize-1:0] id_d    [3];
    logic [IdSize-1:0] id_q    [3];
    logic [IdSize-1:0] id_next [3];
    logic [IdSize-2:0] id_cnt  [3];
    logic              valid_r [3];
    logic              ready_r [3];

    for (genvar r = 0; r < 3; r++) begin : g_replica
        always_comb begin
            state_v[r] = state_q[r];
            data_d[r]  = data_q[r];
            id_v[r]    = id_q[r];

            // Counter bits step, top bit keeps the parity even
            id_cnt[r]  = id_q[r][IdSize-2:0] + 1'b1;
            id_next[r] = {^id_cnt[r], id_cnt[r]};

            valid_r[r] = 1'b1;
            ready_r[r] = 1'b0;

            case (state_q[r])
                STORE_AND_SEND: begin
                    valid_r[r] = valid_i;
                    ready_r[r] = 1'b1;
                    if (valid_i) begin
                        data_d[r] = data_i;
                        id_v[r]   = id_next[r];
                        if (!ready_i) begin
                            state_v[r] = SEND;
                        end else if (enable_i) begin
                            state_v[r] = REPLICATE;
                        end
                    end
                end
                SEND: begin
                    // First copy still waiting downstream
                    if (ready_i) begin
                        state_v[r] = enable_i ? REPLICATE : STORE_AND_SEND;
                    end
                end
                REPLICATE: begin
                    if (ready_i) begin
                        state_v[r] = STORE_AND_SEND;
                    end
                end
                default: begin
                    state_v[r] = STORE_AND_SEND;
                end
            endcase
        end

        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                state_q[r] <= STORE_AND_SEND;
                id_q[r]    <= '0;
            end else begin
                state_q[r] <= state_d[r];
                id_q[r]    <= id_d[r];
            end
        end

        always_ff @(posedge clk_i) begin
            data_q[r] <= data_d[r];
        end
    end

    // Next state and id are corrected before they are stored
    assign state_d = `VOTE3TO3ENUM(state_v);
    assign id_d    = `VOTE3TO3(id_v);

    // Single voted view towards the outside
    assign valid_o = `VOTE3TO1(valid_r);
    assign ready_o = `VOTE3TO1(ready_r);
    assign data_o  = `VOTE3TO1(data_d);
    assign id_o    = `VOTE3TO1(id_v);

endmodule

`default_nettype wire

// File: hw/time_dmr_top.sv
`timescale 1ns/1ns
`default_nettype none

module time_dmr_top
    import time_dmr_pkg::*;
#(
    parameter int IdSize      = ID_SIZE,
    parameter int ResultWidth = RESULT_W
) (
    input  wire           clk_i,
    input  wire           arst_n_i,
    input  wire           enable_i,
    input  wire           in_valid_i,
    output logic          in_ready_o,
    input  wire mac_req_t in_req_i,
    output logic          out_valid_o,
    input  wire           out_ready_i,
    output mac_rsp_t      out_rsp_o
);

    // Start block to pipeline
    logic                   start_valid;
    logic                   start_ready;
    mac_req_t               start_req;
    logic [IdSize-1:0]      start_id;

    // Pipeline to end block
    logic                   pipe_valid;
    logic                   pipe_ready;
    logic [ResultWidth-1:0] pipe_result;
    logic [IdSize-1:0]      pipe_id;

    time_dmr_start #(
        .IdSize (IdSize)
    ) u_start (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .enable_i (enable_i),
        .valid_i  (in_valid_i),
        .ready_o  (in_ready_o),
        .data_i   (in_req_i),
        .valid_o  (start_valid),
        .ready_i  (start_ready),
        .data_o   (start_req),
        .id_o     (start_id)
    );

    mac_pipeline #(
        .IdSize      (IdSize),
        .ResultWidth (ResultWidth)
    ) u_pipeline (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (start_valid),
        .ready_o  (start_ready),
        .req_i    (start_req),
        .id_i     (start_id),
        .valid_o  (pipe_valid),
        .ready_i  (pipe_ready),
        .result_o (pipe_result),
        .id_o     (pipe_id)
    );

    time_dmr_end #(
        .IdSize      (IdSize),
        .ResultWidth (ResultWidth)
    ) u_end (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .enable_i (enable_i),
        .valid_i  (pipe_valid),
        .ready_o  (pipe_ready),
        .result_i (pipe_result),
        .id_i     (pipe_id),
        .valid_o  (out_valid_o),
        .ready_i  (out_ready_i),
        .rsp_o    (out_rsp_o)
    );

endmodule

`default_nettype wire

// File: hw/tmr_voters.svh
`ifndef TMR_VOTERS_SVH
`define TMR_VOTERS_SVH

// Bitwise two-out-of-three majority
`define TMR_MAJ(a, b, c) (((a) & (b)) | ((a) & (c)) | ((b) & (c)))

// Three copies in an unpacked array, one voted value out
`define VOTE3TO1(in) `TMR_MAJ((in[0]), (in[1]), (in[2]))

// Voted value handed back to all three copies
`define VOTE3TO3(in) '{3{`VOTE3TO1(in)}}

// Enums are voted by comparison, a bitwise mix of two codes
// need not be a legal state
`define VOTE3TO3ENUM(in) '{3{(((in[0]) == (in[1])) ? (in[0]) : (in[2]))}}

`endif
